// File: verilog/mmc_params.svh
`ifndef MMC_PARAMS_SVH
`define MMC_PARAMS_SVH

// System clocks per MMC clock half period
`define MMC_CLK_DIV 2

// Largest byte count of one request
`define MMC_MAX_BYTES 4

// CRC7 register width
`define MMC_CRC_W 7

`endif

// File: verilog/mmc_pkg.sv
`include "mmc_params.svh"

package mmc_pkg;

  typedef enum logic [1:0] {
    CMD_RD = 2'd0,
    CMD_WR = 2'd1,
    DAT_RD = 2'd2,
    DAT_WR = 2'd3
  } mmc_op_e;

  typedef enum logic [1:0] {
    DW_1 = 2'd0,
    DW_4 = 2'd1,
    DW_8 = 2'd2
  } mmc_width_e;

  typedef enum logic [2:0] {
    IDLE,
    SHIFT,
    NEXT,
    RESP,
    HOLD
  } mmc_dec_state_e;

  typedef logic [7:0] mmc_byte_t;

  // Write word is right-aligned, first byte sent is the most significant one used
  typedef struct packed {
    mmc_op_e                      op;
    mmc_width_e                   width;
    logic [2:0]                   count;
    logic [`MMC_MAX_BYTES*8-1:0]  wr_word;
  } mmc_req_t;

  typedef struct packed {
    logic [`MMC_MAX_BYTES*8-1:0]  rd_word;
    logic [`MMC_CRC_W-1:0]        crc;
  } mmc_rsp_t;

endpackage

// File: verilog/mmc_req_decode.sv
`timescale 1ns/10ps
`include "mmc_params.svh"

module mmc_req_decode import mmc_pkg::*; (
  input  logic       clk,
  input  logic       reset_i,
  input  logic       req_i,
  input  mmc_req_t   req_data_i,
  input  logic       byte_done_i,
  input  mmc_byte_t  rd_byte_i,
  output logic       adv_en_o,
  output mmc_op_e    op_o,
  output mmc_width_e width_o,
  output mmc_byte_t  wr_byte_o,
  output logic       byte_vld_o,
  output mmc_byte_t  byte_o,
  output logic       first_o,
  output logic       last_o
);

  localparam int WORD_W = `MMC_MAX_BYTES * 8;

  mmc_dec_state_e    state_q;
  mmc_op_e           op_q;
  mmc_width_e        width_q;
  logic [2:0]        left_q;
  logic [WORD_W-1:0] wr_sh_q;
  logic              is_wr;

  assign is_wr = (op_q == CMD_WR) || (op_q == DAT_WR);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= IDLE;
      left_q  <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (req_i) begin
            state_q <= NEXT;
            left_q  <= req_data_i.count;
          end
        end
        NEXT: state_q <= SHIFT;
        SHIFT: begin
          if (byte_done_i) begin
            left_q  <= left_q - 1'b1;
            state_q <= (left_q <= 3'd1) ? RESP : NEXT;
          end
        end
        RESP: state_q <= HOLD;
        HOLD: begin
          // Wait for the controller to release the request
          if (!req_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == IDLE && req_i) begin
      op_q    <= req_data_i.op;
      width_q <= req_data_i.width;
      // Left-justify the payload so the first byte sits on top
      wr_sh_q <= req_data_i.wr_word << {(3'(`MMC_MAX_BYTES) - req_data_i.count), 3'b000};
    end else if (byte_vld_o) begin
      wr_sh_q <= wr_sh_q << 8;
    end
  end

  assign first_o    = (state_q == IDLE) && req_i;
  assign adv_en_o   = (state_q == NEXT);
  assign byte_vld_o = (state_q == SHIFT) && byte_done_i;
  assign last_o     = (state_q == RESP);
  assign wr_byte_o  = wr_sh_q[WORD_W-1 -: 8];
  assign byte_o     = is_wr ? wr_byte_o : rd_byte_i;
  assign op_o       = op_q;
  assign width_o    = width_q;

endmodule

// File: verilog/mmc_clk_div.sv
`timescale 1ns/10ps
`include "mmc_params.svh"

module mmc_clk_div (
  input  logic clk,
  input  logic reset_i,
  input  logic tick_i,
  output logic mmc_clk_o,
  output logic clk_done_o
);

  localparam int CNT_W = $clog2(`MMC_CLK_DIV + 1);

  logic [CNT_W-1:0] cnt_q;
  logic             mmc_clk_q;
  logic             done_q;

  always_ff @(posedge clk) begin
    // Park low with the counter cleared when no byte is moving
    if (reset_i || !tick_i) begin
      cnt_q     <= '0;
      mmc_clk_q <= 1'b0;
      done_q    <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (cnt_q == CNT_W'(`MMC_CLK_DIV - 1)) begin
        cnt_q     <= '0;
        mmc_clk_q <= !mmc_clk_q;
        done_q    <= !mmc_clk_q;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  assign mmc_clk_o  = mmc_clk_q;
  assign clk_done_o = done_q;

endmodule

// File: verilog/mmc_byte_shifter.sv
`timescale 1ns/10ps

module mmc_byte_shifter import mmc_pkg::*; (
  input  logic       clk,
  input  logic       reset_i,
  input  logic       adv_en_i,
  input  mmc_op_e    op_i,
  input  mmc_width_e width_i,
  input  mmc_byte_t  wr_byte_i,
  input  logic       clk_done_i,
  input  logic       mmc_cmd_i,
  input  logic [7:0] mmc_dat_i,
  output logic       tick_o,
  output logic       byte_done_o,
  output mmc_byte_t  rd_byte_o,
  output logic       mmc_cmd_o,
  output logic       mmc_cmd_oe_o,
  output logic [7:0] mmc_dat_o,
  output logic       mmc_dat_oe_o
);

  logic       busy_q;
  logic [2:0] wr_idx_q;
  logic [2:0] rd_idx_q;
  logic [2:0] last_idx;
  mmc_byte_t  rd_acc_q;
  mmc_byte_t  rd_next;
  logic       is_cmd;
  logic       step;

  assign is_cmd = (op_i == CMD_RD) || (op_i == CMD_WR);
  assign step   = busy_q && clk_done_i;

  // Command line is always one bit wide
  always_comb begin
    if (is_cmd) begin
      last_idx = 3'd7;
    end else begin
      case (width_i)
        DW_4:    last_idx = 3'd1;
        DW_8:    last_idx = 3'd0;
        default: last_idx = 3'd7;
      endcase
    end
  end

  assign byte_done_o = step && (rd_idx_q == last_idx);
  assign tick_o      = busy_q;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      busy_q <= 1'b0;
    end else if (adv_en_i) begin
      busy_q <= 1'b1;
    end else if (byte_done_o) begin
      busy_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i || adv_en_i) begin
      wr_idx_q <= '0;
      rd_idx_q <= '0;
    end else if (step) begin
      wr_idx_q <= wr_idx_q + 1'b1;
      rd_idx_q <= rd_idx_q + 1'b1;
    end
  end

  // Write side sends MSB first
  assign mmc_cmd_o = wr_byte_i[~wr_idx_q];

  always_comb begin
    case (width_i)
      DW_4:    mmc_dat_o = {4'h0, wr_idx_q[0] ? wr_byte_i[3:0] : wr_byte_i[7:4]};
      DW_8:    mmc_dat_o = wr_byte_i;
      default: mmc_dat_o = {7'h00, wr_byte_i[~wr_idx_q]};
    endcase
  end

  assign mmc_cmd_oe_o = busy_q && (op_i == CMD_WR);
  assign mmc_dat_oe_o = busy_q && (op_i == DAT_WR);

  // The finished read byte is visible on the last edge
  always_comb begin
    if (is_cmd) begin
      rd_next = {rd_acc_q[6:0], mmc_cmd_i};
    end else begin
      case (width_i)
        DW_4:    rd_next = {rd_acc_q[3:0], mmc_dat_i[3:0]};
        DW_8:    rd_next = mmc_dat_i;
        default: rd_next = {rd_acc_q[6:0], mmc_dat_i[0]};
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (step) begin
      rd_acc_q <= rd_next;
    end
  end

  assign rd_byte_o = rd_next;

  a_done_after_start: assert property (@(posedge clk) disable iff (reset_i)
    byte_done_o |-> $past(busy_q));

  a_no_cmd_dw8: assert property (@(posedge clk) disable iff (reset_i)
    adv_en_i && (width_i == DW_8) |-> !is_cmd);

endmodule

// File: verilog/mmc_resp_build.sv
`timescale 1ns/10ps
`include "mmc_params.svh"

module mmc_resp_build import mmc_pkg::*; (
  input  logic      clk,
  input  logic      reset_i,
  input  logic      req_i,
  input  mmc_op_e   op_i,
  input  logic      byte_vld_i,
  input  mmc_byte_t byte_i,
  input  logic      first_i,
  input  logic      last_i,
  output logic      ack_o,
  output mmc_rsp_t  rsp_o
);

  localparam int WORD_W = `MMC_MAX_BYTES * 8;
  // x^7 + x^3 + 1
  localparam logic [`MMC_CRC_W-1:0] CRC_POLY = 'h09;

  logic [`MMC_CRC_W-1:0] crc_q;
  logic [WORD_W-1:0]     rd_word_q;
  logic                  ack_q;
  logic                  is_rd;

  function automatic logic [`MMC_CRC_W-1:0] crc7_byte(
    input logic [`MMC_CRC_W-1:0] crc,
    input mmc_byte_t             data
  );
    logic [`MMC_CRC_W-1:0] c;
    logic                  fb;
    c = crc;
    for (int i = 7; i >= 0; i--) begin
      fb = c[`MMC_CRC_W-1] ^ data[i];
      c  = {c[`MMC_CRC_W-2:0], 1'b0};
      if (fb) begin
        c = c ^ CRC_POLY;
      end
    end
    return c;
  endfunction

  assign is_rd = (op_i == CMD_RD) || (op_i == DAT_RD);

  always_ff @(posedge clk) begin
    if (first_i) begin
      crc_q     <= '0;
      rd_word_q <= '0;
    end else if (byte_vld_i) begin
      crc_q <= crc7_byte(crc_q, byte_i);
      if (is_rd) begin
        rd_word_q <= {rd_word_q[WORD_W-9:0], byte_i};
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      ack_q <= 1'b0;
    end else if (last_i) begin
      ack_q <= 1'b1;
    end else if (!req_i) begin
      ack_q <= 1'b0;
    end
  end

  assign ack_o         = ack_q;
  assign rsp_o.rd_word = rd_word_q;
  assign rsp_o.crc     = crc_q;

  a_rsp_stable: assert property (@(posedge clk) disable iff (reset_i)
    ack_o |=> !ack_o || $stable(rsp_o));

  a_ack_with_req: assert property (@(posedge clk) disable iff (reset_i)
    $rose(ack_o) |-> req_i);

endmodule

// File: verilog/mmc_host_top.sv
`timescale 1ns/10ps

module mmc_host_top import mmc_pkg::*; (
  input  logic       clk,
  input  logic       reset_i,
  input  logic       req_i,
  input  mmc_req_t   req_data_i,
  output logic       ack_o,
  output mmc_rsp_t   rsp_o,
  output logic       mmc_clk_o,
  input  logic       mmc_cmd_i,
  output logic       mmc_cmd_o,
  output logic       mmc_cmd_oe_o,
  input  logic [7:0] mmc_dat_i,
  output logic [7:0] mmc_dat_o,
  output logic       mmc_dat_oe_o
);

  logic       tick;
  logic       clk_done;
  logic       adv_en;
  mmc_op_e    op;
  mmc_width_e width;
  mmc_byte_t  wr_byte;
  logic       byte_done;
  mmc_byte_t  rd_byte;
  logic       byte_vld;
  mmc_byte_t  byte_val;
  logic       first;
  logic       last;

  mmc_req_decode u_mmc_req_decode (
    .clk         (clk),
    .reset_i     (reset_i),
    .req_i       (req_i),
    .req_data_i  (req_data_i),
    .byte_done_i (byte_done),
    .rd_byte_i   (rd_byte),
    .adv_en_o    (adv_en),
    .op_o        (op),
    .width_o     (width),
    .wr_byte_o   (wr_byte),
    .byte_vld_o  (byte_vld),
    .byte_o      (byte_val),
    .first_o     (first),
    .last_o      (last)
  );

  mmc_clk_div u_mmc_clk_div (
    .clk        (clk),
    .reset_i    (reset_i),
    .tick_i     (tick),
    .mmc_clk_o  (mmc_clk_o),
    .clk_done_o (clk_done)
  );

  mmc_byte_shifter u_mmc_byte_shifter (
    .clk          (clk),
    .reset_i      (reset_i),
    .adv_en_i     (adv_en),
    .op_i         (op),
    .width_i      (width),
    .wr_byte_i    (wr_byte),
    .clk_done_i   (clk_done),
    .mmc_cmd_i    (mmc_cmd_i),
    .mmc_dat_i    (mmc_dat_i),
    .tick_o       (tick),
    .byte_done_o  (byte_done),
    .rd_byte_o    (rd_byte),
    .mmc_cmd_o    (mmc_cmd_o),
    .mmc_cmd_oe_o (mmc_cmd_oe_o),
    .mmc_dat_o    (mmc_dat_o),
    .mmc_dat_oe_o (mmc_dat_oe_o)
  );

  mmc_resp_build u_mmc_resp_build (
    .clk        (clk),
    .reset_i    (reset_i),
    .req_i      (req_i),
    .op_i       (op),
    .byte_vld_i (byte_vld),
    .byte_i     (byte_val),
    .first_i    (first),
    .last_i     (last),
    .ack_o      (ack_o),
    .rsp_o      (rsp_o)
  );

endmodule

// File: test/tb_mmc_card.sv
`timescale 1ns/10ps

module tb_mmc_card import mmc_pkg::*; (
  input  logic        clk,
  input  logic        reset_i,
  input  logic        start_i,
  input  mmc_width_e  width_i,
  input  logic        mmc_clk_i,
  input  logic        mmc_cmd_i,
  input  logic        mmc_cmd_oe_i,
  input  logic [7:0]  mmc_dat_i,
  input  logic        mmc_dat_oe_i,
  output logic        mmc_cmd_o,
  output logic [7:0]  mmc_dat_o,
  output logic [31:0] rx_word_o,
  output logic [2:0]  rx_cnt_o
);

  localparam logic [31:0] READ_PATTERN = 32'hA53C0FF0;

  logic [31:0] tx_q = READ_PATTERN;
  logic        mmc_clk_d = 1'b0;
  logic [7:0]  rx_sh_q = '0;
  int          rx_bits_q = 0;
  logic [31:0] rx_word_q = '0;
  logic [2:0]  rx_cnt_q = '0;

  // MMC clock edges are detected on the falling system clock edge
  always @(negedge clk) begin
    logic [7:0] sh;
    int         bits;
    sh   = rx_sh_q;
    bits = rx_bits_q;
    if (reset_i || start_i) begin
      tx_q      <= READ_PATTERN;
      rx_sh_q   <= '0;
      rx_bits_q <= 0;
      rx_word_q <= '0;
      rx_cnt_q  <= '0;
    end else if (mmc_clk_i && !mmc_clk_d) begin
      // Rising edge, sample what the host drives
      if (mmc_cmd_oe_i) begin
        sh   = {sh[6:0], mmc_cmd_i};
        bits = bits + 1;
      end else if (mmc_dat_oe_i) begin
        case (width_i)
          DW_4: begin
            sh   = {sh[3:0], mmc_dat_i[3:0]};
            bits = bits + 4;
          end
          DW_8: begin
            sh   = mmc_dat_i;
            bits = bits + 8;
          end
          default: begin
            sh   = {sh[6:0], mmc_dat_i[0]};
            bits = bits + 1;
          end
        endcase
      end
      if (bits == 8) begin
        rx_word_q <= {rx_word_q[23:0], sh};
        rx_cnt_q  <= rx_cnt_q + 1'b1;
        bits = 0;
      end
      rx_sh_q   <= sh;
      rx_bits_q <= bits;
    end else if (!mmc_clk_i && mmc_clk_d) begin
      // Next read bits go out after the falling edge
      case (width_i)
        DW_4:    tx_q <= tx_q << 4;
        DW_8:    tx_q <= tx_q << 8;
        default: tx_q <= tx_q << 1;
      endcase
    end
    mmc_clk_d <= mmc_clk_i;
  end

  assign mmc_cmd_o = tx_q[31];

  always_comb begin
    case (width_i)
      DW_4:    mmc_dat_o = {4'h0, tx_q[31:28]};
      DW_8:    mmc_dat_o = tx_q[31:24];
      default: mmc_dat_o = {7'h00, tx_q[31]};
    endcase
  end

  assign rx_word_o = rx_word_q;
  assign rx_cnt_o  = rx_cnt_q;

endmodule

// File: test/tb_mmc_host.sv
`timescale 1ns/10ps
`include "mmc_params.svh"

module tb_mmc_host import mmc_pkg::*; ();

  localparam int NUM_TESTS = 13;

  typedef struct packed {
    mmc_op_e     op;
    mmc_width_e  width;
    logic [2:0]  count;
    logic [1:0]  hold;
    logic [31:0] exp_rd;
  } test_t;

  // Read words hold the card bytes A5 3C 0F F0 right-aligned to the count
  test_t tests [NUM_TESTS] = '{
    '{CMD_WR, DW_1, 3'd1, 2'd0, 32'h0000_0000},
    '{CMD_WR, DW_1, 3'd2, 2'd1, 32'h0000_0000},
    '{CMD_WR, DW_1, 3'd3, 2'd0, 32'h0000_0000},
    '{CMD_WR, DW_1, 3'd4, 2'd3, 32'h0000_0000},
    '{DAT_WR, DW_1, 3'd4, 2'd0, 32'h0000_0000},
    '{DAT_WR, DW_4, 3'd3, 2'd2, 32'h0000_0000},
    '{DAT_WR, DW_8, 3'd4, 2'd1, 32'h0000_0000},
    '{CMD_RD, DW_1, 3'd4, 2'd0, 32'hA53C_0FF0},
    '{CMD_RD, DW_1, 3'd2, 2'd3, 32'h0000_A53C},
    '{DAT_RD, DW_1, 3'd4, 2'd1, 32'hA53C_0FF0},
    '{DAT_RD, DW_4, 3'd4, 2'd0, 32'hA53C_0FF0},
    '{DAT_RD, DW_8, 3'd3, 2'd2, 32'h00A5_3C0F},
    '{DAT_RD, DW_8, 3'd1, 2'd0, 32'h0000_00A5}
  };

  logic        clk = 1'b0;
  logic        reset_i;
  logic        req_i;
  mmc_req_t    req_data_i;
  logic        ack_o;
  mmc_rsp_t    rsp_o;
  logic        mmc_clk_o;
  logic        mmc_cmd_i;
  logic        mmc_cmd_o;
  logic        mmc_cmd_oe_o;
  logic [7:0]  mmc_dat_i;
  logic [7:0]  mmc_dat_o;
  logic        mmc_dat_oe_o;
  logic        card_start;
  mmc_width_e  card_width;
  logic [31:0] rx_word;
  logic [2:0]  rx_cnt;

  always #10 clk = ~clk;

  mmc_host_top u_mmc_host_top (
    .clk          (clk),
    .reset_i      (reset_i),
    .req_i        (req_i),
    .req_data_i   (req_data_i),
    .ack_o        (ack_o),
    .rsp_o        (rsp_o),
    .mmc_clk_o    (mmc_clk_o),
    .mmc_cmd_i    (mmc_cmd_i),
    .mmc_cmd_o    (mmc_cmd_o),
    .mmc_cmd_oe_o (mmc_cmd_oe_o),
    .mmc_dat_i    (mmc_dat_i),
    .mmc_dat_o    (mmc_dat_o),
    .mmc_dat_oe_o (mmc_dat_oe_o)
  );

  tb_mmc_card u_card (
    .clk          (clk),
    .reset_i      (reset_i),
    .start_i      (card_start),
    .width_i      (card_width),
    .mmc_clk_i    (mmc_clk_o),
    .mmc_cmd_i    (mmc_cmd_o),
    .mmc_cmd_oe_i (mmc_cmd_oe_o),
    .mmc_dat_i    (mmc_dat_o),
    .mmc_dat_oe_i (mmc_dat_oe_o),
    .mmc_cmd_o    (mmc_cmd_i),
    .mmc_dat_o    (mmc_dat_i),
    .rx_word_o    (rx_word),
    .rx_cnt_o     (rx_cnt)
  );

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0d ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      $display("ERRORS FOUND");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  // Serial CRC7 with x^7 + x^3 + 1 over the low nbytes of word from the top byte down
  function automatic logic [6:0] crc7_model(input logic [31:0] word, input int nbytes);
    logic [6:0] r;
    logic       in_bit;
    r = '0;
    for (int n = nbytes * 8 - 1; n >= 0; n--) begin
      in_bit = word[n] ^ r[6];
      r      = {r[5:3], r[2] ^ in_bit, r[1:0], in_bit};
    end
    return r;
  endfunction

  task automatic idle_checks(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      check_value("ack_o", ack_o, 0);
      check_value("mmc_clk_o", mmc_clk_o, 0);
      check_value("mmc_cmd_oe_o", mmc_cmd_oe_o, 0);
      check_value("mmc_dat_oe_o", mmc_dat_oe_o, 0);
    end
  endtask

  task automatic run_test(input int idx);
    test_t       t;
    logic [31:0] wr_word;
    logic [31:0] used;
    logic        is_rd;
    logic        oe_seen;
    mmc_rsp_t    held;
    t       = tests[idx];
    wr_word = $urandom;
    used    = wr_word & 32'((64'd1 << (8 * t.count)) - 1);
    is_rd   = (t.op == CMD_RD) || (t.op == DAT_RD);
    oe_seen = 1'b0;
    @(posedge clk);
    req_i      <= 1'b1;
    req_data_i <= '{op: t.op, width: t.width, count: t.count, wr_word: wr_word};
    card_width <= t.width;
    card_start <= 1'b1;
    @(posedge clk);
    card_start <= 1'b0;
    @(negedge clk);
    while (!ack_o) begin
      check_value("mmc_cmd_oe_o", mmc_cmd_oe_o & (t.op != CMD_WR), 0);
      check_value("mmc_dat_oe_o", mmc_dat_oe_o & (t.op != DAT_WR), 0);
      oe_seen = oe_seen | mmc_cmd_oe_o | mmc_dat_oe_o;
      @(negedge clk);
    end
    check_value("oe seen during transfer", oe_seen, !is_rd);
    held = rsp_o;
    check_value("rsp_o.rd_word", rsp_o.rd_word, t.exp_rd);
    if (is_rd) begin
      check_value("rsp_o.crc", rsp_o.crc, crc7_model(t.exp_rd, t.count));
      check_value("card rx_cnt", rx_cnt, 0);
    end else begin
      check_value("rsp_o.crc", rsp_o.crc, crc7_model(used, t.count));
      check_value("card rx_cnt", rx_cnt, t.count);
      check_value("card rx_word", rx_word, used);
    end
    // Response must hold while the controller keeps req_i high
    repeat (t.hold) begin
      @(negedge clk);
      check_value("ack_o", ack_o, 1);
      check_value("rsp_o", rsp_o, held);
      check_value("mmc_clk_o", mmc_clk_o, 0);
    end
    @(posedge clk);
    req_i <= 1'b0;
    @(negedge clk);
    check_value("ack_o", ack_o, 1);
    @(negedge clk);
    check_value("ack_o", ack_o, 0);
    idle_checks(3);
  endtask

  initial begin
    int          limit;
    limit = 5 + 20;
    for (int i = 0; i < NUM_TESTS; i++) begin
      limit = limit + tests[i].count * 8 * 4 * `MMC_CLK_DIV + 20;
    end
    repeat (limit) @(posedge clk);
    $display("Timeout: the tests did not finish within %0d clock cycles", limit);
    $display("ERRORS FOUND");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    int unsigned seed_val;
    seed_val   = 4;
    void'($urandom(seed_val));
    reset_i    = 1'b1;
    req_i      = 1'b0;
    req_data_i = '0;
    card_start = 1'b0;
    card_width = DW_1;
    repeat (5) @(posedge clk);
    reset_i <= 1'b0;
    @(negedge clk);
    check_value("ack_o", ack_o, 0);
    idle_checks(2);
    for (int i = 0; i < NUM_TESTS; i++) begin
      run_test(i);
    end
    $display("NO ERRORS");
    $finish;
  end

endmodule

// File: sources.f
+incdir+verilog
verilog/mmc_pkg.sv
verilog/mmc_req_decode.sv
verilog/mmc_clk_div.sv
verilog/mmc_byte_shifter.sv
verilog/mmc_resp_build.sv
verilog/mmc_host_top.sv
test/tb_mmc_card.sv
test/tb_mmc_host.sv
